/* design/edge_pkg.sv */
`default_nettype none

package edge_pkg;

    // --------------------
    // widths with a meaning
    typedef logic [15:0] rgb565_t;   // r[15:11] g[10:5] b[4:0]
    typedef logic [7:0]  gray_t;     // 8-bit luminance
    typedef logic [3:0]  grade_t;    // sobel grade 0..15
    typedef logic [7:0]  thresh_t;   // grade times step
    typedef logic [10:0] grad_t;     // |gx| + |gy| up to 2040
    typedef logic [2:0]  key_t;      // one bit per key

    // --------------------
    // streams
    typedef struct packed {
        logic    vsync;              // frame strobe
        logic    href;               // line strobe
        logic    valid;              // pixel strobe
        rgb565_t data;
    } pixel_stream_t;

    typedef struct packed {
        logic    vsync;
        logic    href;
        logic    valid;
        gray_t   data;
    } gray_stream_t;

    typedef struct packed {
        logic                vsync;
        logic                href;
        logic                valid;
        gray_t [2:0][2:0]    pix;    // [row][col], row 0 oldest line
    } window_t;

    typedef struct packed {
        logic    flag;               // one-cycle press event
        key_t    value;              // pressed pattern, active high
    } key_event_t;

    typedef enum logic [1:0] {
        MODE_RAW,
        MODE_GRAY,
        MODE_EDGE
    } out_mode_e;

    // --------------------
    // constants
    localparam grade_t  GRADE_RESET      = 4'd4;
    localparam grade_t  GRADE_MAX        = 4'd15;
    localparam int      THRESH_STEP      = 16;    // threshold per grade
    localparam rgb565_t EDGE_PIXEL       = '1;    // white
    localparam rgb565_t BACKGROUND_PIXEL = '0;    // black

endpackage

`default_nettype wire

/* design/key_scan.sv */
`timescale 1ns/1ns
`default_nettype none

module key_scan #(
    parameter int DEBOUNCE_CYCLES = 1_000_000      // stable cycles before a press counts
) (
    input  logic                 clk,
    input  logic                 rst,
    input  edge_pkg::key_t       key_data,         // active low keys
    output edge_pkg::key_event_t key_event
);
    import edge_pkg::*;

    localparam int               CNT_W    = $clog2(DEBOUNCE_CYCLES + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DEBOUNCE_CYCLES - 1);

    key_t             key_meta;      // first sync flop
    key_t             key_sync;      // second sync flop
    key_t             pressed;       // active high pattern
    key_t             pressed_d;     // pattern one cycle ago
    logic             stable;        // same non-zero pattern as last cycle
    logic [CNT_W-1:0] cnt;           // debounce counter
    logic             armed;         // cleared after an event

    assign pressed = ~key_sync;
    assign stable  = (pressed == pressed_d) && (pressed != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            key_meta  <= '1;                       // released
            key_sync  <= '1;
            pressed_d <= '0;
            cnt       <= '0;
            armed     <= 1'b1;
            key_event <= '0;
        end else begin
            key_meta  <= key_data;
            key_sync  <= key_meta;
            pressed_d <= pressed;

            // restart on any change, hold at the end
            if (!stable) begin
                cnt <= '0;
            end else if (cnt != CNT_LAST) begin
                cnt <= cnt + 1'b1;
            end

            key_event.flag <= 1'b0;                // single-cycle pulse
            if (stable && armed && cnt == CNT_LAST) begin
                key_event.flag  <= 1'b1;
                key_event.value <= pressed;
                armed           <= 1'b0;           // wait for full release
            end else if (pressed == '0) begin
                armed <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* design/mode_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module mode_ctrl (
    input  logic                 clk,
    input  logic                 rst,
    input  edge_pkg::key_event_t key_event,
    output edge_pkg::out_mode_e  mode,          // output selection
    output edge_pkg::grade_t     grade,         // shown on leds
    output edge_pkg::thresh_t    threshold      // to sobel compare
);
    import edge_pkg::*;

    out_mode_e mode_next;
    grade_t    grade_next;

    // lowest key index wins
    always_comb begin
        mode_next  = mode;
        grade_next = grade;
        if (key_event.flag) begin
            if (key_event.value[0]) begin              // key 0 steps mode
                case (mode)
                    MODE_RAW:  mode_next = MODE_GRAY;
                    MODE_GRAY: mode_next = MODE_EDGE;
                    default:   mode_next = MODE_RAW;   // wrap
                endcase
            end else if (key_event.value[1]) begin     // key 1 grade up
                if (grade != GRADE_MAX) begin
                    grade_next = grade + 1'b1;
                end
            end else if (key_event.value[2]) begin     // key 2 grade down
                if (grade != '0) begin
                    grade_next = grade - 1'b1;
                end
            end
        end
    end

    // threshold tracks grade in the same cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            mode      <= MODE_RAW;
            grade     <= GRADE_RESET;
            threshold <= thresh_t'(GRADE_RESET * THRESH_STEP);
        end else begin
            mode      <= mode_next;
            grade     <= grade_next;
            threshold <= thresh_t'(grade_next * THRESH_STEP);
        end
    end

endmodule

`default_nettype wire

/* design/rgb_to_gray.sv */
`timescale 1ns/1ns
`default_nettype none

module rgb_to_gray (
    input  logic                    clk,
    input  logic                    rst,
    input  edge_pkg::pixel_stream_t pix_in,
    output edge_pkg::gray_stream_t  gray_out
);
    import edge_pkg::*;

    typedef struct packed {
        logic  vsync;
        logic  href;
        logic  valid;
        gray_t r;
        gray_t g;
        gray_t b;
    } rgb888_stream_t;

    rgb888_stream_t s1;          // widened channels
    logic [15:0]    luma_sum;    // weights add to 256

    assign luma_sum = 16'd77 * s1.r + 16'd150 * s1.g + 16'd29 * s1.b;

    always_ff @(posedge clk) begin
        // --------------------
        // stage one, repeat top bits
        s1.r <= {pix_in.data[15:11], pix_in.data[15:13]};
        s1.g <= {pix_in.data[10:5],  pix_in.data[10:9]};
        s1.b <= {pix_in.data[4:0],   pix_in.data[4:2]};
        // --------------------
        // stage two, keep upper byte
        gray_out.data <= luma_sum[15:8];

        if (rst) begin
            s1.vsync       <= 1'b0;
            s1.href        <= 1'b0;
            s1.valid       <= 1'b0;
            gray_out.vsync <= 1'b0;
            gray_out.href  <= 1'b0;
            gray_out.valid <= 1'b0;
        end else begin
            s1.vsync       <= pix_in.vsync;
            s1.href        <= pix_in.href;
            s1.valid       <= pix_in.valid;
            gray_out.vsync <= s1.vsync;        // strobes two cycles late
            gray_out.href  <= s1.href;
            gray_out.valid <= s1.valid;
        end
    end

endmodule

`default_nettype wire

/* design/line_window.sv */
`timescale 1ns/1ns
`default_nettype none

module line_window #(
    parameter int LINE_WIDTH = 1024                 // pixels per line
) (
    input  logic                   clk,
    input  logic                   rst,
    input  edge_pkg::gray_stream_t gray_in,
    output edge_pkg::window_t      window
);
    import edge_pkg::*;

    localparam int             COL_W    = (LINE_WIDTH > 1) ? $clog2(LINE_WIDTH) : 1;
    localparam logic [COL_W-1:0] COL_LAST = COL_W'(LINE_WIDTH - 1);

    gray_t            line0_mem [0:LINE_WIDTH-1];   // two lines back
    gray_t            line1_mem [0:LINE_WIDTH-1];   // previous line
    logic [COL_W-1:0] col;                          // column of the incoming pixel
    logic [1:0]       lines_seen;                   // saturates at 2
    logic             vsync_d;
    logic             href_d;
    logic             vsync_rise;                   // frame start
    logic             href_rise;                    // line start
    logic             pix_en;                       // pixel counts
    gray_t            up2;                          // row 0 sample
    gray_t            up1;                          // row 1 sample
    gray_t [2:0][2:0] win_next;

    assign vsync_rise = gray_in.vsync && !vsync_d;
    assign href_rise  = gray_in.href && !href_d;
    assign pix_en     = gray_in.href && gray_in.valid;

    // lines not yet written this frame read as zero
    assign up2 = (lines_seen == 2'd2) ? line0_mem[col] : '0;
    assign up1 = (lines_seen != 2'd0) ? line1_mem[col] : '0;

    // --------------------
    // window shift
    always_comb begin
        win_next = window.pix;
        if (href_rise) begin
            win_next = '0;                          // left border padding
        end
        if (pix_en) begin
            for (int r = 0; r < 3; r++) begin
                win_next[r][0] = win_next[r][1];
                win_next[r][1] = win_next[r][2];
            end
            win_next[0][2] = up2;
            win_next[1][2] = up1;
            win_next[2][2] = gray_in.data;          // newest pixel
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vsync_d      <= 1'b0;
            href_d       <= 1'b0;
            col          <= '0;
            lines_seen   <= '0;
            window       <= '0;                     // contents too
        end else begin
            vsync_d      <= gray_in.vsync;
            href_d       <= gray_in.href;
            window.vsync <= gray_in.vsync;
            window.href  <= gray_in.href;
            window.valid <= pix_en;
            window.pix   <= win_next;
            if (vsync_rise) begin
                col        <= '0;
                lines_seen <= '0;
            end else if (pix_en) begin
                col <= (col == COL_LAST) ? '0 : col + 1'b1;
                if (col == COL_LAST && lines_seen != 2'd2) begin
                    lines_seen <= lines_seen + 1'b1;
                end
            end
        end
    end

    // --------------------
    // line memories
    always_ff @(posedge clk) begin
        if (pix_en) begin
            line0_mem[col] <= line1_mem[col];       // age one line
            line1_mem[col] <= gray_in.data;
        end
    end

endmodule

`default_nettype wire

/* design/sobel_detect.sv */
`timescale 1ns/1ns
`default_nettype none

module sobel_detect (
    input  logic                   clk,
    input  logic                   rst,
    input  edge_pkg::window_t      window,
    input  edge_pkg::thresh_t      threshold,
    output edge_pkg::gray_stream_t edge_out       // all ones on an edge
);
    import edge_pkg::*;

    typedef struct packed {
        logic  vsync;
        logic  href;
        logic  valid;
        grad_t gx;                                 // |gx|
        grad_t gy;                                 // |gy|
    } grad_stage_t;

    grad_stage_t s1;
    logic [9:0]  gx_pos;                           // right column
    logic [9:0]  gx_neg;                           // left column
    logic [9:0]  gy_pos;                           // newest row
    logic [9:0]  gy_neg;                           // oldest row
    grad_t       mag;
    logic        is_edge;

    // 1 2 1 weighted sum of three taps
    function automatic logic [9:0] tap3(input gray_t a, input gray_t b, input gray_t c);
        return {2'b00, a} + {1'b0, b, 1'b0} + {2'b00, c};
    endfunction

    function automatic grad_t abs_diff(input logic [9:0] a, input logic [9:0] b);
        return (a >= b) ? {1'b0, a - b} : {1'b0, b - a};
    endfunction

    assign gx_pos = tap3(window.pix[0][2], window.pix[1][2], window.pix[2][2]);
    assign gx_neg = tap3(window.pix[0][0], window.pix[1][0], window.pix[2][0]);
    assign gy_pos = tap3(window.pix[2][0], window.pix[2][1], window.pix[2][2]);
    assign gy_neg = tap3(window.pix[0][0], window.pix[0][1], window.pix[0][2]);

    assign mag     = s1.gx + s1.gy;                // no overflow in 11 bits
    assign is_edge = mag > grad_t'(threshold);     // strictly above

    always_ff @(posedge clk) begin
        // --------------------
        // stage one, absolute gradients
        s1.gx <= abs_diff(gx_pos, gx_neg);
        s1.gy <= abs_diff(gy_pos, gy_neg);
        // --------------------
        // stage two, compare
        edge_out.data <= is_edge ? '1 : '0;

        if (rst) begin
            s1.vsync       <= 1'b0;
            s1.href        <= 1'b0;
            s1.valid       <= 1'b0;
            edge_out.vsync <= 1'b0;
            edge_out.href  <= 1'b0;
            edge_out.valid <= 1'b0;
        end else begin
            s1.vsync       <= window.vsync;
            s1.href        <= window.href;
            s1.valid       <= window.valid;
            edge_out.vsync <= s1.vsync;
            edge_out.href  <= s1.href;
            edge_out.valid <= s1.valid;
        end
    end

endmodule

`default_nettype wire

/* design/sobel_edge_detector.sv */
`timescale 1ns/1ns
`default_nettype none

module sobel_edge_detector #(
    parameter int LINE_WIDTH      = 1024,           // pixels per line
    parameter int DEBOUNCE_CYCLES = 1_000_000       // key debounce length
) (
    input  logic                    clk,
    input  logic                    rst,
    input  edge_pkg::pixel_stream_t pix_in,         // rgb565 camera stream
    input  edge_pkg::key_t          key_data,       // active low keys
    output edge_pkg::pixel_stream_t pix_out,
    output edge_pkg::grade_t        led_data        // current sobel grade
);
    import edge_pkg::*;

    key_event_t    key_event;
    out_mode_e     mode;                            // follows keys at once
    out_mode_e     frame_mode;                      // held for one frame
    thresh_t       threshold;
    gray_stream_t  gray_s;                          // 2 cycles behind pix_in
    window_t       window_s;                        // 3 cycles
    gray_stream_t  edge_s;                          // 5 cycles
    pixel_stream_t sel;
    logic          vsync_prev;

    // --------------------
    // control
    key_scan #(
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
    ) u_key_scan (
        .clk       (clk),
        .rst       (rst),
        .key_data  (key_data),
        .key_event (key_event)
    );

    mode_ctrl u_mode_ctrl (
        .clk       (clk),
        .rst       (rst),
        .key_event (key_event),
        .mode      (mode),
        .grade     (led_data),                      // grade straight to leds
        .threshold (threshold)
    );

    // --------------------
    // video path
    rgb_to_gray u_rgb_to_gray (
        .clk      (clk),
        .rst      (rst),
        .pix_in   (pix_in),
        .gray_out (gray_s)
    );

    line_window #(
        .LINE_WIDTH (LINE_WIDTH)
    ) u_line_window (
        .clk     (clk),
        .rst     (rst),
        .gray_in (gray_s),
        .window  (window_s)
    );

    sobel_detect u_sobel_detect (
        .clk       (clk),
        .rst       (rst),
        .window    (window_s),
        .threshold (threshold),
        .edge_out  (edge_s)
    );

    // --------------------
    // output select
    always_comb begin
        case (frame_mode)
            MODE_GRAY: begin
                sel.vsync = gray_s.vsync;
                sel.href  = gray_s.href;
                sel.valid = gray_s.valid;
                sel.data  = {gray_s.data[7:3], gray_s.data[7:2], gray_s.data[7:3]};
            end
            MODE_EDGE: begin
                sel.vsync = edge_s.vsync;
                sel.href  = edge_s.href;
                sel.valid = edge_s.valid;
                sel.data  = (edge_s.data == '1) ? EDGE_PIXEL : BACKGROUND_PIXEL;
            end
            default: begin
                sel = pix_in;                       // raw camera pixels
            end
        endcase
    end

    // the frame gap must cover the 5-cycle edge path before the next vsync
    always_ff @(posedge clk) begin
        pix_out.data <= sel.data;
        if (rst) begin
            vsync_prev    <= 1'b0;
            frame_mode    <= MODE_RAW;
            pix_out.vsync <= 1'b0;
            pix_out.href  <= 1'b0;
            pix_out.valid <= 1'b0;
        end else begin
            vsync_prev    <= pix_in.vsync;
            if (pix_in.vsync && !vsync_prev) begin
                frame_mode <= mode;                 // latch at frame start
            end
            pix_out.vsync <= sel.vsync;
            pix_out.href  <= sel.href;
            pix_out.valid <= sel.valid;
        end
    end

endmodule

`default_nettype wire

/* testbench/tb_pixel_model.svh */
`ifndef TB_PIXEL_MODEL_SVH
`define TB_PIXEL_MODEL_SVH

// --------------------
// frame store
rgb565_t frame_pix  [0:ROWS-1][0:COLS-1];     // camera pixels of the frame
int      frame_luma [0:ROWS-1][0:COLS-1];     // luminance of the same pixels
rgb565_t expect_q   [$];                      // expected outputs, in order

// channels widened by bit repeat, then 77/150/29 weights over 256
function automatic int luma_of(input rgb565_t p);
    int r8;
    int g8;
    int b8;
    r8 = (int'(p[15:11]) << 3) | (int'(p[15:11]) >> 2);
    g8 = (int'(p[10:5]) << 2) | (int'(p[10:5]) >> 4);
    b8 = (int'(p[4:0]) << 3) | (int'(p[4:0]) >> 2);
    return (77 * r8 + 150 * g8 + 29 * b8) >> 8;
endfunction

function automatic rgb565_t luma_to_rgb565(input int y);
    return rgb565_t'(((y >> 3) << 11) | ((y >> 2) << 5) | (y >> 3));
endfunction

function automatic int luma_at(input int y, input int x);
    if (y < 0 || x < 0) begin
        return 0;                                 // zero padding above and left
    end
    return frame_luma[y][x];
endfunction

// window ends at (y, x), kernels built from row and column offsets
function automatic int sobel_mag(input int y, input int x);
    int gx;
    int gy;
    int s;
    gx = 0;
    gy = 0;
    for (int r = 0; r < 3; r++) begin
        for (int c = 0; c < 3; c++) begin
            s  = luma_at(y - 2 + r, x - 2 + c);
            gx += (c - 1) * ((r == 1) ? 2 : 1) * s;   // right minus left
            gy += (r - 1) * ((c == 1) ? 2 : 1) * s;   // newest minus oldest
        end
    end
    return ((gx < 0) ? -gx : gx) + ((gy < 0) ? -gy : gy);
endfunction

task automatic queue_frame(input out_mode_e mode, input int grade);
    for (int y = 0; y < ROWS; y++) begin
        for (int x = 0; x < COLS; x++) begin
            frame_luma[y][x] = luma_of(frame_pix[y][x]);
        end
    end
    for (int y = 0; y < ROWS; y++) begin
        for (int x = 0; x < COLS; x++) begin
            case (mode)
                MODE_RAW:  expect_q.push_back(frame_pix[y][x]);
                MODE_GRAY: expect_q.push_back(luma_to_rgb565(frame_luma[y][x]));
                default: begin
                    if (sobel_mag(y, x) > grade * THRESH_PER_GRADE) begin
                        expect_q.push_back(16'hFFFF);   // edge
                    end else begin
                        expect_q.push_back(16'h0000);   // background
                    end
                end
            endcase
        end
    end
endtask

`endif

/* testbench/tb_sobel_edge_detector.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_sobel_edge_detector;
    import edge_pkg::*;

    localparam int COLS             = 16;
    localparam int ROWS             = 8;
    localparam int DEBOUNCE         = 8;
    localparam int THRESH_PER_GRADE = 16;
    localparam int RESET_CYCLES     = 10;
    localparam int VSYNC_CYCLES     = 4;          // vsync pulse width
    localparam int PRE_CYCLES       = 4;          // idle after vsync
    localparam int LINE_GAP         = 6;          // idle between lines
    localparam int DRAIN_CYCLES     = 12;         // covers the 6-cycle edge path
    localparam int HOLD_CYCLES      = 3 * DEBOUNCE;
    localparam int RELEASE_CYCLES   = DEBOUNCE;
    localparam int NUM_FRAMES       = 9;
    localparam int NUM_PRESSES      = 35;
    localparam int FRAME_CYCLES     = VSYNC_CYCLES + PRE_CYCLES
                                    + ROWS * (2 * COLS + LINE_GAP) + DRAIN_CYCLES;
    localparam int PRESS_CYCLES     = HOLD_CYCLES + RELEASE_CYCLES;
    localparam int TOTAL_CYCLES     = RESET_CYCLES + NUM_FRAMES * FRAME_CYCLES
                                    + NUM_PRESSES * PRESS_CYCLES;
    localparam int TIMEOUT_CYCLES   = 2 * TOTAL_CYCLES;

    logic          clk;
    logic          rst;
    pixel_stream_t pix_in;
    key_t          key_data;                      // active low
    pixel_stream_t pix_out;
    grade_t        led_data;

    out_mode_e     model_mode;                    // mode the next frame gets
    int            model_grade;
    int            cycle_count = 0;
    int            pixel_count = 0;               // checked output pixels
    logic          out_vsync_seen = 1'b0;         // output vsync since last frame start

    `include "tb_pixel_model.svh"

    sobel_edge_detector #(
        .LINE_WIDTH      (COLS),
        .DEBOUNCE_CYCLES (DEBOUNCE)
    ) DUT (
        .clk      (clk),
        .rst      (rst),
        .pix_in   (pix_in),
        .key_data (key_data),
        .pix_out  (pix_out),
        .led_data (led_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;                   // 40 ns period
    end

    // --------------------
    // helpers
    task automatic abort_run(input string line);
        $display("%s", line);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input int actual, input int expected, input string what);
        if (actual != expected) begin
            abort_run($sformatf("Fail at %0t ns: %s, got %0h, expected %0h",
                                $time, what, actual, expected));
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic press_key(input int idx, input int count);
        for (int i = 0; i < count; i++) begin
            key_data = ~(key_t'(1) << idx);       // hold well past debounce
            wait_cycles(HOLD_CYCLES);
            key_data = '1;
            wait_cycles(RELEASE_CYCLES);
            case (idx)
                0: begin
                    case (model_mode)
                        MODE_RAW:  model_mode = MODE_GRAY;
                        MODE_GRAY: model_mode = MODE_EDGE;
                        default:   model_mode = MODE_RAW;   // wraps
                    endcase
                end
                1: model_grade = (model_grade < 15) ? model_grade + 1 : 15;
                default: model_grade = (model_grade > 0) ? model_grade - 1 : 0;
            endcase
            check_value(int'(led_data), model_grade, $sformatf("led_data after key %0d", idx));
        end
    endtask

    // gap_key below zero means no key inside the frame
    task automatic drive_frame(input int gap_key);
        pix_in       = '0;
        pix_in.vsync = 1'b1;                      // frame start
        wait_cycles(VSYNC_CYCLES);
        pix_in.vsync = 1'b0;
        if (gap_key >= 0) begin
            press_key(gap_key, 1);                // after vsync, counts from the next frame
        end
        wait_cycles(PRE_CYCLES);
        for (int y = 0; y < ROWS; y++) begin
            for (int x = 0; x < COLS; x++) begin
                pix_in.href  = 1'b1;
                pix_in.valid = 1'b1;
                pix_in.data  = frame_pix[y][x];
                @(negedge clk);
                if (x != COLS - 1 && $urandom_range(3) == 0) begin
                    pix_in.valid = 1'b0;          // single-cycle gap
                    pix_in.data  = rgb565_t'($urandom);
                    @(negedge clk);
                end
            end
            pix_in = '0;
            wait_cycles(LINE_GAP);
        end
        wait_cycles(DRAIN_CYCLES);
    endtask

    // --------------------
    // output checker
    always @(negedge clk) begin
        if (!rst && pix_out.vsync) begin
            out_vsync_seen = 1'b1;
        end
        if (!rst && pix_out.valid) begin
            if (expect_q.size() == 0) begin
                abort_run("An output pixel appeared that no input pixel accounts for.");
            end else begin
                check_value(int'(pix_out.href), 1, "output href with a valid pixel");
                if (pixel_count % (ROWS * COLS) == 0) begin
                    check_value(int'(out_vsync_seen), 1, "output vsync before frame");
                    out_vsync_seen = 1'b0;
                end
                check_value(int'(pix_out.data), int'(expect_q.pop_front()),
                            $sformatf("output pixel %0d", pixel_count));
                pixel_count++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            abort_run("The run took too many clock cycles and was stopped by the timeout.");
        end
    end

    // --------------------
    // stimulus
    initial begin
        void'($urandom(32));
        rst          = 1'b1;
        pix_in       = '0;
        pix_in.href  = 1'b1;                      // live pixels while in reset
        pix_in.valid = 1'b1;
        pix_in.data  = rgb565_t'($urandom);
        key_data     = '1;                        // all released
        model_mode   = MODE_RAW;
        model_grade  = 4;
        wait_cycles(RESET_CYCLES);
        rst    = 1'b0;
        pix_in = '0;
        check_value(int'(pix_out.valid), 0, "output valid after reset");
        check_value(int'(led_data), 4, "led_data after reset");
        wait_cycles(2);

        for (int f = 0; f < NUM_FRAMES; f++) begin
            case (f)                              // keys only between frames
                1: press_key(0, 1);               // grey
                2: press_key(0, 1);               // edge
                3: press_key(2, 5);               // down to 0, one extra
                4: press_key(1, 16);              // up to 15, one extra
                5: press_key(2, 7);
                6: press_key(0, 1);               // back to raw
                8: begin
                    press_key(0, 1);
                    press_key(1, 2);
                end
                default: ;
            endcase
            for (int y = 0; y < ROWS; y++) begin
                for (int x = 0; x < COLS; x++) begin
                    frame_pix[y][x] = rgb565_t'($urandom);
                end
            end
            queue_frame(model_mode, model_grade);
            drive_frame((f == 6) ? 0 : -1);       // frame 7 turns grey from inside frame 6
        end

        if (expect_q.size() != 0) begin
            abort_run($sformatf("%0d expected output pixels never appeared.", expect_q.size()));
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+testbench
design/edge_pkg.sv
design/key_scan.sv
design/mode_ctrl.sv
design/rgb_to_gray.sv
design/line_window.sv
design/sobel_detect.sv
design/sobel_edge_detector.sv
testbench/tb_sobel_edge_detector.sv

/* Makefile */
VERILATOR  = verilator
VFLAGS     = --binary --timing -j 0
LINT_FLAGS = --lint-only --timing
TOP        = tb_sobel_edge_detector
FILELIST   = src.f
OBJ_DIR    = obj_dir
PASS_MSG   = NO ERRORS

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: build
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
